// ==== common/fetch_pkg.sv ====
/*
 * shared widths, enums and packed structs of the RV32I fetch frontend
 */
package fetch_pkg;

    localparam int ADDR_W      = 32;
    localparam int INSTR_W     = 32;
    localparam int INSTR_BYTES = 4;

    // control-flow class found by pre-decode
    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JUMPR,
        CF_CALL,
        CF_RETURN
    } cf_e;

    typedef enum logic [1:0] {
        FS_BOOT,
        FS_REQ,
        FS_WAIT,
        FS_DRAIN
    } fetch_state_e;

    // ------------------------------------------------------------
    // instruction memory port
    // ------------------------------------------------------------
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic               gnt;
        logic               rvalid;
        logic [INSTR_W-1:0] rdata;
    } imem_rsp_t;

    // ------------------------------------------------------------
    // frontend internals and decode side
    // ------------------------------------------------------------
    typedef struct packed {
        cf_e               cf;
        logic [ADDR_W-1:0] imm;
        logic              is_rvi_valid;  // opcode[1:0] == 2'b11
    } scan_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
        cf_e                cf;
        logic               pred_taken;
        logic [ADDR_W-1:0]  pred_target;
    } fetch_entry_t;

    // single-cycle pulses from the back end
    typedef struct packed {
        logic              mispredict_valid;
        logic [ADDR_W-1:0] mispredict_target;
        logic              eret_valid;
        logic [ADDR_W-1:0] epc;
        logic              trap_valid;
        logic [ADDR_W-1:0] trap_base;
    } redirect_t;

endpackage

// ==== frontend/fetch_ctrl.sv ====
/*
 * fetch FSM: issues one memory request at a time and drops
 * responses whose request was killed by a redirect
 */
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic queue_full_i,
    input  logic redirect_valid_i,
    input  logic gnt_i,
    input  logic rvalid_i,
    output logic req_o,
    output logic rsp_take_o,
    output logic boot_o
);

    fetch_state_e state_q, state_d;

    always_comb begin
        state_d    = state_q;
        req_o      = 1'b0;
        rsp_take_o = 1'b0;
        unique case (state_q)
            FS_BOOT: begin
                state_d = FS_REQ;
            end
            FS_REQ: begin
                req_o = !queue_full_i && !redirect_valid_i;
                if (req_o && gnt_i) begin
                    // memory may answer in the grant cycle
                    if (rvalid_i) begin
                        rsp_take_o = 1'b1;
                    end else begin
                        state_d = FS_WAIT;
                    end
                end
            end
            FS_WAIT: begin
                if (rvalid_i) begin
                    // a redirect in the same cycle kills this word
                    rsp_take_o = !redirect_valid_i;
                    state_d    = FS_REQ;
                end else if (redirect_valid_i) begin
                    state_d = FS_DRAIN;
                end
            end
            FS_DRAIN: begin
                // stale response, swallow it
                if (rvalid_i) begin
                    state_d = FS_REQ;
                end
            end
            default: begin
                state_d = FS_BOOT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FS_BOOT;
        end else begin
            state_q <= state_d;
        end
    end

    assign boot_o = (state_q == FS_BOOT);

    // a response only ever belongs to the single accepted request
    a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> (state_q inside {FS_WAIT, FS_DRAIN}) || (req_o && gnt_i));

endmodule

// ==== frontend/pc_gen.sv ====
/*
 * fetch PC register with prioritized next-PC selection
 */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter logic [ADDR_W-1:0] BOOT_ADDR = 32'h80
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              boot_i,
    input  logic              rsp_take_i,
    input  redirect_t         redirect_i,
    input  logic              pred_taken_i,
    input  logic [ADDR_W-1:0] pred_target_i,
    output logic [ADDR_W-1:0] pc_o
);

    logic [ADDR_W-1:0] pc_q, pc_d;

    // trap > eret > mispredict > prediction > sequential
    always_comb begin
        pc_d = pc_q;
        if (boot_i) begin
            pc_d = BOOT_ADDR;
        end else if (redirect_i.trap_valid) begin
            pc_d = redirect_i.trap_base;
        end else if (redirect_i.eret_valid) begin
            pc_d = redirect_i.epc;
        end else if (redirect_i.mispredict_valid) begin
            pc_d = redirect_i.mispredict_target;
        end else if (rsp_take_i) begin
            pc_d = pred_taken_i ? pred_target_i : pc_q + ADDR_W'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== frontend/instr_scan.sv ====
/*
 * pre-decode of one RV32I word into control-flow class and immediate
 */
`timescale 1ns/1ps

module instr_scan import fetch_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,
    output scan_t              scan_o
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [4:0] rd;
    logic [4:0] rs1;
    logic       rd_link;
    logic       rs1_link;

    assign rd  = instr_i[11:7];
    assign rs1 = instr_i[19:15];

    // x1 and x5 are the link registers of the calling convention
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    always_comb begin
        scan_o.cf           = CF_NONE;
        scan_o.imm          = '0;
        scan_o.is_rvi_valid = (instr_i[1:0] == 2'b11);
        unique case (instr_i[6:0])
            OPC_BRANCH: begin
                scan_o.cf  = CF_BRANCH;
                scan_o.imm = {{(ADDR_W-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                scan_o.cf  = rd_link ? CF_CALL : CF_JUMP;
                scan_o.imm = {{(ADDR_W-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (rd_link) begin
                    scan_o.cf = CF_CALL;
                end else if (rd == 5'd0 && rs1_link) begin
                    scan_o.cf = CF_RETURN;
                end else begin
                    scan_o.cf = CF_JUMPR;
                end
                scan_o.imm = {{(ADDR_W-12){instr_i[31]}}, instr_i[31:20]};
            end
            default: begin
                scan_o.cf = CF_NONE;
            end
        endcase
    end

endmodule

// ==== frontend/branch_predict.sv ====
/*
 * static next-PC prediction and return stack steering
 */
`timescale 1ns/1ps

module branch_predict import fetch_pkg::*; (
    input  logic [ADDR_W-1:0]  pc_i,
    input  logic [INSTR_W-1:0] instr_i,
    input  logic               rsp_take_i,
    input  logic [ADDR_W-1:0]  ras_top_i,
    input  logic               ras_valid_i,
    output scan_t              scan_o,
    output logic               pred_taken_o,
    output logic [ADDR_W-1:0]  pred_target_o,
    output logic               ras_push_o,
    output logic               ras_pop_o,
    output logic [ADDR_W-1:0]  push_addr_o
);

    scan_t             scan;
    logic              is_jal;
    logic [ADDR_W-1:0] pc_plus4;

    instr_scan u_instr_scan (
        .instr_i (instr_i),
        .scan_o  (scan)
    );

    assign scan_o   = scan;
    assign is_jal   = (instr_i[6:0] == 7'b1101111);
    assign pc_plus4 = pc_i + ADDR_W'(INSTR_BYTES);

    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = pc_plus4;
        if (scan.is_rvi_valid) begin
            unique case (scan.cf)
                // backward taken, forward not taken
                CF_BRANCH: pred_taken_o = scan.imm[ADDR_W-1];
                CF_JUMP:   pred_taken_o = 1'b1;
                CF_CALL:   pred_taken_o = is_jal;
                CF_RETURN: pred_taken_o = ras_valid_i;
                default:   pred_taken_o = 1'b0;
            endcase
            if (pred_taken_o) begin
                pred_target_o = (scan.cf == CF_RETURN) ? ras_top_i : pc_i + scan.imm;
            end
        end
    end

    // the stack only moves for words that really enter the queue
    assign ras_push_o  = rsp_take_i && scan.is_rvi_valid && (scan.cf == CF_CALL);
    assign ras_pop_o   = rsp_take_i && scan.is_rvi_valid && (scan.cf == CF_RETURN);
    assign push_addr_o = pc_plus4;

endmodule

// ==== frontend/ras.sv ====
/*
 * circular return address stack, oldest entry lost on overflow
 */
`timescale 1ns/1ps

module ras import fetch_pkg::*; #(
    parameter int RAS_DEPTH = 2
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push_i,
    input  logic              pop_i,
    input  logic [ADDR_W-1:0] push_addr_i,
    input  logic              flush_i,
    output logic [ADDR_W-1:0] top_o,
    output logic              top_valid_o
);

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

    logic [ADDR_W-1:0]    addr_q  [RAS_DEPTH];
    logic [RAS_DEPTH-1:0] valid_q;
    logic [PTR_W-1:0]     tp_q;
    logic [PTR_W-1:0]     tp_inc;
    logic [PTR_W-1:0]     tp_dec;

    assign tp_inc = (tp_q == PTR_W'(RAS_DEPTH-1)) ? '0 : tp_q + 1'b1;
    assign tp_dec = (tp_q == '0) ? PTR_W'(RAS_DEPTH-1) : tp_q - 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            tp_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (push_i) begin
            tp_q          <= tp_inc;
            valid_q[tp_inc] <= 1'b1;
        end else if (pop_i && valid_q[tp_q]) begin
            // popping an empty stack leaves it alone
            valid_q[tp_q] <= 1'b0;
            tp_q          <= tp_dec;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            addr_q[tp_inc] <= push_addr_i;
        end
    end

    assign top_o       = addr_q[tp_q];
    assign top_valid_o = valid_q[tp_q];

    a_no_push_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_i && pop_i));

endmodule

// ==== frontend/fetch_queue.sv ====
/*
 * fetch entry FIFO toward decode with occupancy counter
 */
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         push_i,
    input  fetch_entry_t entry_i,
    output logic         full_o,
    output fetch_entry_t entry_o,
    output logic         valid_o,
    input  logic         ready_i
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t     mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign pop     = valid_o && ready_i;
    assign entry_o = mem_q[rptr_q];

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wptr_q <= (wptr_q == PTR_W'(QUEUE_DEPTH-1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(QUEUE_DEPTH-1)) ? '0 : rptr_q + 1'b1;
            end
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wptr_q] <= entry_i;
        end
    end

    // fetch_ctrl must hold off requests while the queue is full
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);

endmodule

// ==== src/frontend_top.sv ====
/*
 * RV32I fetch frontend: FSM, PC generation, static prediction,
 * return stack and fetch queue toward decode
 */
`timescale 1ns/1ps

module frontend_top import fetch_pkg::*; #(
    parameter int                QUEUE_DEPTH = 4,
    parameter int                RAS_DEPTH   = 2,
    parameter logic [ADDR_W-1:0] BOOT_ADDR   = 32'h80
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    output imem_req_t    imem_req_o,
    input  imem_rsp_t    imem_rsp_i,
    input  redirect_t    redirect_i,
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_entry_valid_o,
    input  logic         fetch_entry_ready_i
);

    logic              req;
    logic              rsp_take;
    logic              boot;
    logic              queue_full;
    logic              redirect_flush;
    logic [ADDR_W-1:0] pc;
    scan_t             scan;
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_target;
    logic              ras_push;
    logic              ras_pop;
    logic [ADDR_W-1:0] push_addr;
    logic [ADDR_W-1:0] ras_top;
    logic              ras_valid;
    fetch_entry_t      entry;

    assign redirect_flush = redirect_i.trap_valid | redirect_i.eret_valid
                          | redirect_i.mispredict_valid;

    assign imem_req_o.req  = req;
    assign imem_req_o.addr = pc;

    fetch_ctrl u_fetch_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .queue_full_i     (queue_full),
        .redirect_valid_i (redirect_flush),
        .gnt_i            (imem_rsp_i.gnt),
        .rvalid_i         (imem_rsp_i.rvalid),
        .req_o            (req),
        .rsp_take_o       (rsp_take),
        .boot_o           (boot)
    );

    pc_gen #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_pc_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .boot_i        (boot),
        .rsp_take_i    (rsp_take),
        .redirect_i    (redirect_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .pc_o          (pc)
    );

    branch_predict u_branch_predict (
        .pc_i          (pc),
        .instr_i       (imem_rsp_i.rdata),
        .rsp_take_i    (rsp_take),
        .ras_top_i     (ras_top),
        .ras_valid_i   (ras_valid),
        .scan_o        (scan),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .ras_push_o    (ras_push),
        .ras_pop_o     (ras_pop),
        .push_addr_o   (push_addr)
    );

    ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (push_addr),
        .flush_i     (redirect_flush),
        .top_o       (ras_top),
        .top_valid_o (ras_valid)
    );

    // entry for decode, pc of the word that was just returned
    assign entry.pc          = pc;
    assign entry.instr       = imem_rsp_i.rdata;
    assign entry.cf          = scan.cf;
    assign entry.pred_taken  = pred_taken;
    assign entry.pred_target = pred_target;

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (redirect_flush),
        .push_i  (rsp_take),
        .entry_i (entry),
        .full_o  (queue_full),
        .entry_o (fetch_entry_o),
        .valid_o (fetch_entry_valid_o),
        .ready_i (fetch_entry_ready_i)
    );

endmodule

// ==== tb/tb_frontend.sv ====
/*
 * testbench for the fetch frontend: instruction memory model,
 * directed tests, watchdog and closing report
 */
`timescale 1ns/1ps

module tb_frontend import fetch_pkg::*; ();

    localparam int                CLK_PERIOD      = 40;
    localparam int                QUEUE_DEPTH     = 4;
    localparam int                RAS_DEPTH       = 2;
    localparam logic [ADDR_W-1:0] BOOT_ADDR       = 32'h80;
    localparam int                MEM_WORDS       = 1024;
    // 8 + 6 + 7 + 20 + 5 * 3 entries over all tests
    localparam int                TOTAL_ENTRIES   = 56;
    localparam int                WATCHDOG_CYCLES = TOTAL_ENTRIES * 8 + 600;

    logic         clk;
    logic         rst_n;
    imem_req_t    mem_req;
    imem_rsp_t    mem_rsp;
    redirect_t    redirect;
    fetch_entry_t entry;
    logic         entry_valid;
    logic         entry_ready;

    logic [31:0]  mem [MEM_WORDS];
    logic         rsp_pending;
    logic [1:0]   wait_cnt;
    logic [31:0]  pend_addr;
    logic         hold_rsp;
    logic [15:0]  mem_lfsr;
    logic [15:0]  bp_lfsr;

    fetch_entry_t got [$];
    logic [31:0]  exp_pc [$];
    cf_e          exp_cf [$];
    logic         exp_taken [$];
    int           n_checks;
    int           n_errors;

    frontend_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RAS_DEPTH   (RAS_DEPTH),
        .BOOT_ADDR   (BOOT_ADDR)
    ) u_frontend_top (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .imem_req_o          (mem_req),
        .imem_rsp_i          (mem_rsp),
        .redirect_i          (redirect),
        .fetch_entry_o       (entry),
        .fetch_entry_valid_o (entry_valid),
        .fetch_entry_ready_i (entry_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // ------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------
    function automatic logic [31:0] addi_word(input logic [11:0] k);
        return {k, 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // beq x0, x0, off
    function automatic logic [31:0] branch_word(input int off);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // lui x0 carrying the word index so that every address differs
    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return {10'd0, idx, 5'd0, 7'b0110111};
    endfunction

    // ------------------------------------------------------------
    // instruction memory model that always grants
    // ------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rsp.gnt    <= 1'b1;
            mem_rsp.rvalid <= 1'b0;
            mem_rsp.rdata  <= '0;
            rsp_pending    <= 1'b0;
            wait_cnt       <= '0;
            pend_addr      <= '0;
        end else begin
            mem_rsp.rvalid <= 1'b0;
            if (rsp_pending) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else if (!hold_rsp) begin
                    mem_rsp.rvalid <= 1'b1;
                    mem_rsp.rdata  <= mem[pend_addr[11:2]];
                    rsp_pending    <= 1'b0;
                end
            end else if (mem_req.req && mem_rsp.gnt) begin
                // 0 to 3 extra cycles before rvalid
                mem_lfsr = lfsr_step(mem_lfsr);
                wait_cnt[0] <= mem_lfsr[0];
                mem_lfsr = lfsr_step(mem_lfsr);
                wait_cnt[1] <= mem_lfsr[0];
                pend_addr   <= mem_req.addr;
                rsp_pending <= 1'b1;
            end
        end
    end

    // decode side records every transferred entry
    always @(posedge clk) begin
        if (rst_n && entry_valid && entry_ready) begin
            got.push_back(entry);
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic flag_error(input string msg);
        n_errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic load_fill();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i[9:0]);
        end
    endtask

    task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
        mem[addr[11:2]] = word;
    endtask

    task automatic clear_expect();
        exp_pc.delete();
        exp_cf.delete();
        exp_taken.delete();
    endtask

    task automatic expect_entry(input logic [31:0] pc, input cf_e cf, input logic taken);
        exp_pc.push_back(pc);
        exp_cf.push_back(cf);
        exp_taken.push_back(taken);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n       <= 1'b0;
        redirect    <= '0;
        entry_ready <= 1'b1;
        hold_rsp    <= 1'b0;
        repeat (2) @(posedge clk);
        n_checks++;
        if (mem_req.req || entry_valid) begin
            flag_error("req or entry valid active during reset");
        end
        got.delete();
        rst_n <= 1'b1;
    endtask

    task automatic wait_for_entries();
        while (got.size() < exp_pc.size()) begin
            @(posedge clk);
        end
    endtask

    task automatic compare_stream(input string name);
        fetch_entry_t e;
        logic [31:0]  pc;
        for (int i = 0; i < exp_pc.size(); i++) begin
            e  = got[i];
            pc = exp_pc[i];
            n_checks++;
            if (e.pc !== pc) begin
                flag_error($sformatf("%s entry %0d pc %h, expected %h", name, i, e.pc, pc));
            end
            if (e.instr !== mem[pc[11:2]]) begin
                flag_error($sformatf("%s entry %0d instr %h, expected %h",
                                     name, i, e.instr, mem[pc[11:2]]));
            end
            if (e.cf !== exp_cf[i]) begin
                flag_error($sformatf("%s entry %0d cf %s, expected %s",
                                     name, i, e.cf.name(), exp_cf[i].name()));
            end
            if (e.pred_taken !== exp_taken[i]) begin
                flag_error($sformatf("%s entry %0d pred_taken %b, expected %b",
                                     name, i, e.pred_taken, exp_taken[i]));
            end
            if (exp_taken[i] && (i + 1 < exp_pc.size()) && e.pred_target !== exp_pc[i+1]) begin
                flag_error($sformatf("%s entry %0d pred_target %h, expected %h",
                                     name, i, e.pred_target, exp_pc[i+1]));
            end
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic sequential_fetch();
        load_fill();
        clear_expect();
        for (int i = 0; i < 8; i++) begin
            put_word(BOOT_ADDR + 32'(4 * i), addi_word(12'(i + 1)));
            expect_entry(BOOT_ADDR + 32'(4 * i), CF_NONE, 1'b0);
        end
        apply_reset();
        @(posedge clk);
        n_checks++;
        if (mem_req.req) begin
            flag_error("req raised in the first cycle after reset");
        end
        @(posedge clk);
        n_checks++;
        if (!mem_req.req || mem_req.addr !== BOOT_ADDR) begin
            flag_error($sformatf("first request req %b addr %h, expected addr %h",
                                 mem_req.req, mem_req.addr, BOOT_ADDR));
        end
        wait_for_entries();
        compare_stream("sequential");
    endtask

    task automatic static_prediction();
        load_fill();
        put_word(32'h80, jal_word(5'd0, 32'h20));
        put_word(32'h84, addi_word(12'd5));
        put_word(32'h88, addi_word(12'd6));
        put_word(32'ha0, branch_word(8));
        put_word(32'ha4, jalr_word(5'd0, 5'd6));
        put_word(32'ha8, branch_word(-36));
        clear_expect();
        expect_entry(32'h80, CF_JUMP, 1'b1);
        expect_entry(32'ha0, CF_BRANCH, 1'b0);
        expect_entry(32'ha4, CF_JUMPR, 1'b0);
        expect_entry(32'ha8, CF_BRANCH, 1'b1);
        expect_entry(32'h84, CF_NONE, 1'b0);
        expect_entry(32'h88, CF_NONE, 1'b0);
        apply_reset();
        wait_for_entries();
        compare_stream("static prediction");
    endtask

    // two nested calls fill the stack and the third return finds it empty
    task automatic call_return();
        load_fill();
        put_word(32'h80, jal_word(5'd1, 32'h80));
        put_word(32'h100, jal_word(5'd1, 32'h80));
        put_word(32'h180, addi_word(12'd7));
        put_word(32'h184, jalr_word(5'd0, 5'd1));
        put_word(32'h104, jalr_word(5'd0, 5'd1));
        put_word(32'h84, jalr_word(5'd0, 5'd5));
        put_word(32'h88, addi_word(12'd8));
        clear_expect();
        expect_entry(32'h80, CF_CALL, 1'b1);
        expect_entry(32'h100, CF_CALL, 1'b1);
        expect_entry(32'h180, CF_NONE, 1'b0);
        expect_entry(32'h184, CF_RETURN, 1'b1);
        expect_entry(32'h104, CF_RETURN, 1'b1);
        expect_entry(32'h84, CF_RETURN, 1'b0);
        expect_entry(32'h88, CF_NONE, 1'b0);
        apply_reset();
        wait_for_entries();
        compare_stream("call and return");
    endtask

    task automatic back_pressure();
        logic       ready_lvl;
        int         stretch;
        logic [2:0] len;
        load_fill();
        put_word(32'h80, addi_word(12'd1));
        put_word(32'h84, addi_word(12'd2));
        put_word(32'h88, jal_word(5'd1, 32'h78));
        put_word(32'h100, addi_word(12'd3));
        put_word(32'h104, addi_word(12'd4));
        put_word(32'h108, jalr_word(5'd0, 5'd1));
        put_word(32'h8c, branch_word(16));
        clear_expect();
        expect_entry(32'h80, CF_NONE, 1'b0);
        expect_entry(32'h84, CF_NONE, 1'b0);
        expect_entry(32'h88, CF_CALL, 1'b1);
        expect_entry(32'h100, CF_NONE, 1'b0);
        expect_entry(32'h104, CF_NONE, 1'b0);
        expect_entry(32'h108, CF_RETURN, 1'b1);
        expect_entry(32'h8c, CF_BRANCH, 1'b0);
        for (int i = 0; i < 13; i++) begin
            expect_entry(32'h90 + 32'(4 * i), CF_NONE, 1'b0);
        end
        apply_reset();
        ready_lvl = 1'b1;
        stretch   = 0;
        while (got.size() < exp_pc.size()) begin
            @(posedge clk);
            if (stretch == 0) begin
                // low stretches of 24 to 31 cycles fill the queue and high ones last 1 to 8
                ready_lvl = !ready_lvl;
                for (int b = 0; b < 3; b++) begin
                    bp_lfsr = lfsr_step(bp_lfsr);
                    len[b]  = bp_lfsr[0];
                end
                stretch = ready_lvl ? int'(len) + 1 : int'(len) + 24;
            end
            stretch     = stretch - 1;
            entry_ready <= ready_lvl;
        end
        entry_ready <= 1'b1;
        compare_stream("back-pressure");
    endtask

    // redirect with a word waiting in the queue and the response
    // to a granted request held back
    task automatic redirect_case(input redirect_t pulse, input logic [31:0] target);
        load_fill();
        clear_expect();
        for (int i = 0; i < 3; i++) begin
            expect_entry(target + 32'(4 * i), CF_NONE, 1'b0);
        end
        apply_reset();
        while (got.size() < 2) begin
            @(posedge clk);
        end
        entry_ready <= 1'b0;
        @(posedge clk);
        while (!entry_valid) begin
            @(posedge clk);
        end
        hold_rsp <= 1'b1;
        @(posedge clk);
        while (!rsp_pending) begin
            @(posedge clk);
        end
        redirect <= pulse;
        @(posedge clk);
        redirect    <= '0;
        hold_rsp    <= 1'b0;
        entry_ready <= 1'b1;
        got.delete();
        wait_for_entries();
        compare_stream($sformatf("redirect to %h", target));
    endtask

    task automatic redirect_checks();
        redirect_t r;
        r = '0;
        r.trap_valid = 1'b1;
        r.trap_base  = 32'h200;
        redirect_case(r, 32'h200);
        r = '0;
        r.eret_valid = 1'b1;
        r.epc        = 32'h300;
        redirect_case(r, 32'h300);
        r = '0;
        r.mispredict_valid  = 1'b1;
        r.mispredict_target = 32'h400;
        redirect_case(r, 32'h400);
        // trap wins when all three arrive at once
        r.trap_valid        = 1'b1;
        r.trap_base         = 32'h500;
        r.eret_valid        = 1'b1;
        r.epc               = 32'h600;
        r.mispredict_target = 32'h700;
        redirect_case(r, 32'h500);
        r = '0;
        r.eret_valid        = 1'b1;
        r.epc               = 32'h640;
        r.mispredict_valid  = 1'b1;
        r.mispredict_target = 32'h740;
        redirect_case(r, 32'h640);
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        mem_rsp     = '0;
        redirect    = '0;
        entry_ready = 1'b0;
        hold_rsp    = 1'b0;
        mem_lfsr    = 16'd5179;
        bp_lfsr     = 16'd5179;
        n_checks    = 0;
        n_errors    = 0;
        load_fill();

        sequential_fetch();
        static_prediction();
        call_return();
        back_pressure();
        redirect_checks();

        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
common/fetch_pkg.sv
frontend/fetch_ctrl.sv
frontend/pc_gen.sv
frontend/instr_scan.sv
frontend/branch_predict.sv
frontend/ras.sv
frontend/fetch_queue.sv
src/frontend_top.sv
tb/tb_frontend.sv

// ==== Makefile ====
# Verilator build and run of the fetch frontend testbench

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
